// ==== logic/csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// csr numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// crmd after reset: da=1, ie=0, plv=0
`define CRMD_RESET  9'h008

`define TIMER_W     32

// exception codes
`define ECODE_INT   6'h00
`define ECODE_ADE   6'h08
`define ECODE_ALE   6'h09
`define ECODE_TLBR  6'h3f

`endif

// ==== logic/csr_pkg.sv ====
`include "csr_config.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        CSRRD,
        CSRWR,
        CSRXCHG,
        ERTN,
        EXCP
    } csr_op_e;

    typedef struct packed {
        logic [1:0]  rsvd;
        logic [13:0] num;
    } csr_num_t;

    typedef struct packed {
        logic       valid;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } excp_arg_t;

    // csr number for csr ops, exception cause for excp
    typedef union packed {
        csr_num_t  csr;
        excp_arg_t excp;
    } csr_arg_u;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        csr_arg_u    arg;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [31:0] badv;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        csr_arg_u    arg;
        logic [31:0] wval;  // already merged
        logic [31:0] pc;
        logic [31:0] badv;
    } csr_cmd_t;

    typedef struct packed {
        logic [31:0] era;
        logic [31:0] eentry;
        logic        irq_pending;
    } csr_vec_t;

    typedef struct packed {
        logic [`TIMER_W-1:0] tcfg;
        logic [`TIMER_W-1:0] tval;
        logic                ti;
    } timer_state_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        is_excp;
    } csr_redirect_t;

    function automatic logic is_csr_write(csr_cmd_t c);
        return c.valid && (c.op == CSRWR || c.op == CSRXCHG);
    endfunction

endpackage

// ==== logic/csr_control.sv ====
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_control (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_req_t      req,
    input  logic [31:0]            rd_now,
    input  csr_pkg::csr_vec_t      vec,
    output csr_pkg::csr_cmd_t      cmd,
    output logic [31:0]            rd_data,
    output csr_pkg::csr_redirect_t redirect
);
    import csr_pkg::*;

    logic        irq_take;
    logic [31:0] wmask;
    csr_cmd_t    nxt;

    // an entry still in commit has not cleared IE yet, so don't take it twice
    assign irq_take = req.valid && vec.irq_pending && !(cmd.valid && cmd.op == EXCP);

    assign wmask = (req.op == CSRWR) ? '1 : req.mask;

    always_comb
    begin
        nxt.valid = req.valid;
        nxt.op    = req.op;
        nxt.arg   = req.arg;
        nxt.wval  = (rd_now & ~wmask) | (req.wdata & wmask);
        nxt.pc    = req.pc;
        nxt.badv  = req.badv;
        if (irq_take)
        begin
            // interrupt replaces the request, era gets its pc
            nxt.op                = EXCP;
            nxt.arg.excp.valid    = 1'b1;
            nxt.arg.excp.esubcode = '0;
            nxt.arg.excp.ecode    = `ECODE_INT;
        end
    end

    always_ff @(posedge clk)
    begin
        cmd              <= nxt;
        rd_data          <= rd_now;   // pre-commit value
        redirect.valid   <= nxt.valid && (nxt.op == ERTN || nxt.op == EXCP);
        redirect.is_excp <= nxt.op == EXCP;
        if (nxt.op == EXCP)
            redirect.pc <= vec.eentry;
        else
            redirect.pc <= vec.era;
        if (!rstn)
        begin
            cmd.valid      <= 1'b0;
            redirect.valid <= 1'b0;
        end
    end

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [13:0]           rd_num,
    input  csr_pkg::csr_cmd_t     cmd,
    input  csr_pkg::timer_state_t tstate,
    input  logic [7:0]            ext_irq,
    output logic [31:0]           rd_now,
    output csr_pkg::csr_vec_t     vec
);
    import csr_pkg::*;

    logic [8:0]  crmd;
    logic [2:0]  prmd;
    logic [11:0] ecfg_lie;        // bit 10 reserved
    logic [1:0]  estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [25:0] eentry;          // va[31:6]
    logic [31:0] save [4];
    logic [31:0] tid;
    logic [11:0] int_vec;
    logic [13:0] wr_num;
    logic        excp_commit;

    assign wr_num      = cmd.arg.csr.num;
    assign excp_commit = cmd.valid && cmd.op == EXCP;

    // ti, ipi(unused), hwi, swi
    assign int_vec         = {tstate.ti, 1'b0, ext_irq, estat_is};
    assign vec.irq_pending = crmd[2] && |(int_vec & ecfg_lie);
    assign vec.era         = era;
    assign vec.eentry      = {eentry, 6'b0};

    always_comb
    begin
        rd_now = '0;
        case (rd_num)
            `CSR_CRMD:
                rd_now = {23'b0, crmd};
            `CSR_PRMD:
                rd_now = {29'b0, prmd};
            `CSR_ECFG:
                rd_now = {20'b0, ecfg_lie};
            `CSR_ESTAT:
                rd_now = {1'b0, estat_esubcode, estat_ecode, 4'b0, int_vec};
            `CSR_ERA:
                rd_now = era;
            `CSR_BADV:
                rd_now = badv;
            `CSR_EENTRY:
                rd_now = {eentry, 6'b0};
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_now = save[rd_num[1:0]];
            `CSR_TID:
                rd_now = tid;
            `CSR_TCFG:
                rd_now = 32'(tstate.tcfg);
            `CSR_TVAL:
                rd_now = 32'(tstate.tval);
            default:
                rd_now = '0;   // ticlr and unknown numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd     <= `CRMD_RESET;
            prmd     <= '0;
            ecfg_lie <= '0;
            estat_is <= '0;
        end
        else if (excp_commit)
        begin
            prmd      <= crmd[2:0];
            crmd[2:0] <= 3'b0;   // plv0, ie off
        end
        else if (cmd.valid && cmd.op == ERTN)
            crmd[2:0] <= prmd;
        else if (is_csr_write(cmd))
        begin
            case (wr_num)
                `CSR_CRMD:
                    crmd <= cmd.wval[8:0];
                `CSR_PRMD:
                    prmd <= cmd.wval[2:0];
                `CSR_ECFG:
                    ecfg_lie <= {cmd.wval[11], 1'b0, cmd.wval[9:0]};
                `CSR_ESTAT:
                    estat_is <= cmd.wval[1:0];   // only swi bits writable
                default:
                    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (excp_commit)
        begin
            era            <= cmd.pc;
            estat_ecode    <= cmd.arg.excp.ecode;
            estat_esubcode <= cmd.arg.excp.esubcode;
            if (cmd.arg.excp.ecode inside {`ECODE_ALE, `ECODE_ADE, `ECODE_TLBR})
                badv <= cmd.badv;
        end
        else if (is_csr_write(cmd))
        begin
            case (wr_num)
                `CSR_ERA:
                    era <= cmd.wval;
                `CSR_BADV:
                    badv <= cmd.wval;
                `CSR_EENTRY:
                    eentry <= cmd.wval[31:6];
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                    save[wr_num[1:0]] <= cmd.wval;
                `CSR_TID:
                    tid <= cmd.wval;
                default:
                    ;
            endcase
        end
    end

endmodule

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_timer (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_pkg::csr_cmd_t     cmd,
    output csr_pkg::timer_state_t tstate
);
    import csr_pkg::*;

    logic [`TIMER_W-1:0] tcfg;   // [0] en, [1] periodic, rest initval
    logic [`TIMER_W-1:0] tval;
    logic [`TIMER_W-1:0] initval;
    logic                ti;
    logic                tcfg_wr;
    logic                ticlr_wr;

    assign tcfg_wr  = is_csr_write(cmd) && cmd.arg.csr.num == `CSR_TCFG;
    assign ticlr_wr = is_csr_write(cmd) && cmd.arg.csr.num == `CSR_TICLR && cmd.wval[0];
    assign initval  = {tcfg[`TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
            begin
                tcfg <= cmd.wval[`TIMER_W-1:0];
                tval <= {cmd.wval[`TIMER_W-1:2], 2'b00};   // load and start
            end
            else if (tcfg[0] && tcfg[1] && tval == '0)
                tval <= initval;
            else if (tcfg[0] && tval != '1)
                tval <= tval - 1'b1;   // one-shot wraps to all ones and parks

            if (ticlr_wr)
                ti <= 1'b0;
            else if (!tcfg_wr && tcfg[0] && tval == '0)
                ti <= 1'b1;
        end
    end

    assign tstate.tcfg = tcfg;
    assign tstate.tval = tval;
    assign tstate.ti   = ti;

endmodule

// ==== logic/csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_req_t      req,
    input  logic [7:0]             ext_irq,
    output logic [31:0]            rd_data,
    output csr_pkg::csr_redirect_t redirect
);
    import csr_pkg::*;

    csr_cmd_t     cmd;
    csr_vec_t     vec;
    timer_state_t tstate;
    logic [31:0]  rd_now;

    csr_control csr_control_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .rd_now   (rd_now),
        .vec      (vec),
        .cmd      (cmd),
        .rd_data  (rd_data),
        .redirect (redirect)
    );

    // read port looks at the incoming request
    csr_file csr_file_inst (
        .clk     (clk),
        .rstn    (rstn),
        .rd_num  (req.arg.csr.num),
        .cmd     (cmd),
        .tstate  (tstate),
        .ext_irq (ext_irq),
        .rd_now  (rd_now),
        .vec     (vec)
    );

    csr_timer csr_timer_inst (
        .clk    (clk),
        .rstn   (rstn),
        .cmd    (cmd),
        .tstate (tstate)
    );

endmodule

// ==== verification/csr_unit_properties.sv ====
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_unit_properties (
    input logic                   clk,
    input logic                   rstn,
    input csr_pkg::csr_req_t      req,
    input logic [31:0]            rd_data,
    input csr_pkg::csr_cmd_t      cmd,
    input csr_pkg::csr_vec_t      vec,
    input csr_pkg::timer_state_t  tstate,
    input csr_pkg::csr_redirect_t redirect
);
    import csr_pkg::*;

    logic irq_take;

    // no second entry while one is still committing
    assign irq_take = req.valid && vec.irq_pending && !(cmd.valid && cmd.op == EXCP);

    reset_state: assert property (@(posedge clk)
        !rstn |=> !redirect.valid && !cmd.valid && !tstate.ti)
        else $error("state not cleared by reset");

    // save register read one idle cycle after its write
    write_then_read: assert property (@(posedge clk) disable iff (!rstn)
        req.valid && req.op == CSRRD
        && req.arg.csr.num inside {`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3}
        && !$past(req.valid) && $past(req.valid, 2) && $past(req.op, 2) == CSRWR
        && $past(req.arg.csr.num, 2) == req.arg.csr.num && !$past(vec.irq_pending, 2)
        |=> rd_data == $past(req.wdata, 3))
        else $error("save register did not read back the written data");

    redirect_latency: assert property (@(posedge clk) disable iff (!rstn)
        req.valid && (req.op == ERTN || req.op == EXCP) |=> redirect.valid)
        else $error("no redirect one cycle after ertn or excp");

    redirect_cause: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid |-> $past(req.valid))
        else $error("redirect without a request");

    excp_target: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid && redirect.is_excp |-> redirect.pc == $past(vec.eentry))
        else $error("exception redirect not to eentry");

    ertn_target: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid && !redirect.is_excp |-> redirect.pc == $past(vec.era))
        else $error("ertn redirect not to era");

    irq_entry: assert property (@(posedge clk) disable iff (!rstn)
        irq_take |=> cmd.valid && cmd.op == EXCP && cmd.arg.excp.ecode == `ECODE_INT
                     && redirect.valid && redirect.is_excp)
        else $error("pending interrupt not taken");

    ti_source: assert property (@(posedge clk) disable iff (!rstn)
        $rose(tstate.ti) |-> $past(tstate.tval) == '0)
        else $error("timer flag set before countdown reached zero");

    ti_clear: assert property (@(posedge clk) disable iff (!rstn)
        cmd.valid && cmd.op == CSRWR && cmd.arg.csr.num == `CSR_TICLR && cmd.wval[0]
        |=> !tstate.ti)
        else $error("ticlr did not clear the timer flag");

endmodule

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int TIMEOUT = 64;

    logic          clk;
    logic          rstn;
    csr_req_t      req;
    logic [7:0]    ext_irq;
    logic [31:0]   rd_data;
    csr_redirect_t redirect;

    logic [31:0] lfsr = 32'h18a3_2dcd;
    int          checks;
    int          test_errs;
    int          tests_run;
    int          tests_failed;

    csr_unit_top csr_unit_top_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .ext_irq  (ext_irq),
        .rd_data  (rd_data),
        .redirect (redirect)
    );

    bind csr_unit_top csr_unit_properties csr_unit_properties_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .rd_data  (rd_data),
        .cmd      (cmd),
        .vec      (vec),
        .tstate   (tstate),
        .redirect (redirect)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic csr_arg_u num_arg(input logic [13:0] num);
        csr_arg_u a;
        a.csr.rsvd = '0;
        a.csr.num  = num;
        return a;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic load_req(input csr_op_e op, input csr_arg_u arg, input logic [31:0] wdata,
                            input logic [31:0] mask, input logic [31:0] pc,
                            input logic [31:0] badv);
        req.valid = 1'b1;
        req.op    = op;
        req.arg   = arg;
        req.wdata = wdata;
        req.mask  = mask;
        req.pc    = pc;
        req.badv  = badv;
    endtask

    // one-cycle request, returns just after the edge that took it
    task automatic drive_req(input csr_op_e op, input csr_arg_u arg, input logic [31:0] wdata,
                             input logic [31:0] mask, input logic [31:0] pc,
                             input logic [31:0] badv);
        @(posedge clk);
        #1;
        load_req(op, arg, wdata, mask, pc, badv);
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    task automatic csr_access(input csr_op_e op, input logic [13:0] num,
                              input logic [31:0] wdata, input logic [31:0] mask,
                              output logic [31:0] rd);
        drive_req(op, num_arg(num), wdata, mask, '0, '0);
        rd = rd_data;
    endtask

    task automatic wait_redirect(output int cycles);
        cycles = 1;
        while (!redirect.valid && cycles < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!redirect.valid)
        begin
            $display("redirect never pulsed within %0d cycles at %0t", TIMEOUT, $time);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial
    begin
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] old;
        logic [31:0] rd;
        logic [31:0] pc;
        logic [31:0] badv;
        logic [31:0] ee;
        csr_arg_u    a;
        int          cyc;

        clk     = 1'b0;
        rstn    = 1'b0;
        req     = '0;
        ext_irq = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        csr_access(CSRRD, `CSR_CRMD, '0, '0, rd);
        check_eq("rd_data", rd, {23'b0, `CRMD_RESET});
        check_eq("redirect.valid", {31'b0, redirect.valid}, 32'h0);
        end_test("reset crmd");

        take_bits(32, d);
        csr_access(CSRWR, `CSR_SAVE2, d, '1, rd);
        csr_access(CSRRD, `CSR_SAVE2, '0, '0, rd);
        check_eq("rd_data", rd, d);
        csr_access(CSRRD, 14'h3ff, '0, '0, rd);   // unused number
        check_eq("rd_data", rd, 32'h0);
        end_test("write and read");

        take_bits(32, old);
        take_bits(32, d);
        take_bits(32, m);
        csr_access(CSRWR, `CSR_SAVE1, old, '1, rd);
        csr_access(CSRXCHG, `CSR_SAVE1, d, m, rd);
        check_eq("rd_data", rd, old);
        csr_access(CSRRD, `CSR_SAVE1, '0, '0, rd);
        check_eq("rd_data", rd, (old & ~m) | (d & m));
        end_test("masked exchange");

        // plv 3, ie on, no local enables yet
        csr_access(CSRWR, `CSR_CRMD, 32'h0000_000f, '1, rd);
        take_bits(32, ee);
        ee = ee & 32'hffff_ffc0;   // entry is 64-byte aligned
        csr_access(CSRWR, `CSR_EENTRY, ee, '1, rd);
        take_bits(32, pc);
        pc = pc & 32'hffff_fffc;
        take_bits(32, badv);
        a.excp.valid    = 1'b1;
        a.excp.esubcode = '0;
        a.excp.ecode    = `ECODE_ALE;
        drive_req(EXCP, a, '0, '0, pc, badv);
        wait_redirect(cyc);
        check_eq("redirect latency", cyc, 1);
        check_eq("redirect.pc", redirect.pc, ee);
        check_eq("redirect.is_excp", {31'b0, redirect.is_excp}, 32'h1);
        csr_access(CSRRD, `CSR_ERA, '0, '0, rd);
        check_eq("era", rd, pc);
        csr_access(CSRRD, `CSR_BADV, '0, '0, rd);
        check_eq("badv", rd, badv);
        csr_access(CSRRD, `CSR_ESTAT, '0, '0, rd);
        check_eq("estat.ecode", {26'b0, rd[21:16]}, {26'b0, `ECODE_ALE});
        csr_access(CSRRD, `CSR_CRMD, '0, '0, rd);
        check_eq("crmd", rd, 32'h0000_0008);
        csr_access(CSRRD, `CSR_PRMD, '0, '0, rd);
        check_eq("prmd", rd, 32'h0000_0007);
        end_test("exception entry");

        drive_req(ERTN, num_arg('0), '0, '0, '0, '0);
        wait_redirect(cyc);
        check_eq("redirect.pc", redirect.pc, pc);
        check_eq("redirect.is_excp", {31'b0, redirect.is_excp}, 32'h0);
        csr_access(CSRRD, `CSR_CRMD, '0, '0, rd);
        check_eq("crmd", rd, 32'h0000_000f);
        end_test("exception return");

        csr_access(CSRWR, `CSR_ECFG, 32'h0000_0800, '1, rd);   // lie bit 11
        csr_access(CSRWR, `CSR_TCFG, 32'h0000_0011, '1, rd);   // initval 16, one-shot
        pc = 32'h1c00_0100;
        @(posedge clk);
        #1;
        load_req(CSRRD, num_arg(`CSR_SAVE0), '0, '0, pc, '0);
        cyc = 0;
        while (!redirect.valid && cyc < 16 + TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cyc++;
        end
        req.valid = 1'b0;
        if (!redirect.valid)
        begin
            $display("timer interrupt never taken within %0d cycles", 16 + TIMEOUT);
            test_errs++;
        end
        check_eq("redirect.is_excp", {31'b0, redirect.is_excp}, 32'h1);
        check_eq("redirect.pc", redirect.pc, ee);
        csr_access(CSRRD, `CSR_ESTAT, '0, '0, rd);
        check_eq("estat.ecode", {26'b0, rd[21:16]}, {26'b0, `ECODE_INT});
        check_eq("estat.ti", {31'b0, rd[11]}, 32'h1);
        csr_access(CSRRD, `CSR_ERA, '0, '0, rd);
        check_eq("era", rd, pc);
        csr_access(CSRWR, `CSR_TICLR, 32'h1, '1, rd);
        csr_access(CSRRD, `CSR_ESTAT, '0, '0, rd);
        check_eq("estat.ti", {31'b0, rd[11]}, 32'h0);
        end_test("timer interrupt");

        $display("%0d tests, %0d failing, %0d checks", tests_run, tests_failed, checks);
        if (tests_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_control.sv
logic/csr_file.sv
logic/csr_timer.sv
logic/csr_unit_top.sv
verification/csr_unit_properties.sv
verification/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the csr unit testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module csr_unit_tb -Mdir "$BUILD" -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/csr_unit_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
